// ==== all.f ====
xpu_pkg.sv
xpu_cfg_regs.sv
tsf_timer.sv
phy_rx_parse.sv
xpu_ctrl.sv
xpu.sv
xpu_tb.sv

// ==== Bender.yml ====
package:
  name: xpu

sources:
  - xpu_pkg.sv
  - xpu_cfg_regs.sv
  - tsf_timer.sv
  - phy_rx_parse.sv
  - xpu_ctrl.sv
  - xpu.sv
  - target: simulation
    files:
      - xpu_tb.sv

// ==== xpu_tb.sv ====
// self-checking testbench for xpu; runs with CLK_PER_US = 5 so one us is five 4 ns clocks
`timescale 1ns/1ns

module xpu_tb;

    localparam int CLK_PER_US = 5;

    logic               clk;
    logic               rst_n;
    logic               reg_wr_en;
    xpu_pkg::reg_addr_t reg_addr;
    xpu_pkg::reg_data_t reg_wr_data;
    logic               hdr_strobe;
    logic               byte_strobe;
    logic [7:0]         byte_in;
    logic [15:0]        byte_count;
    logic               demod;
    logic               fcs_strobe;
    logic               tx_rf;

    xpu_pkg::band_t     band;
    xpu_pkg::channel_t  channel;
    xpu_pkg::ifs_time_t slot_time;
    xpu_pkg::ifs_time_t sifs_time;
    xpu_pkg::mac_addr_t mac_addr;
    xpu_pkg::tsf_t      tsf_val;
    logic               tsf_pulse;
    xpu_pkg::fc_di_t    fc_di;
    logic               fc_di_valid;
    xpu_pkg::mac_addr_t addr1;
    logic               addr1_valid;
    xpu_pkg::mac_addr_t addr2;
    logic               addr2_valid;
    logic               pkt_for_me;
    logic               ch_idle;
    logic               mute_adc;

    // testbench copies of what was written
    xpu_pkg::reg_data_t band_word;
    xpu_pkg::reg_data_t ovr_word;
    xpu_pkg::mac_addr_t my_mac;
    logic [7:0]         hdr_bytes [0:15];

    integer seed;
    int     tests;
    int     checks;
    int     failures;
    int     fail_mark;

    xpu #(
        .CLK_PER_US (CLK_PER_US)
    ) xpu_i (
        .s00_axi_aclk_i            (clk),
        .rst_n_i                   (rst_n),
        .reg_wr_en_i               (reg_wr_en),
        .reg_addr_i                (reg_addr),
        .reg_wr_data_i             (reg_wr_data),
        .pkt_header_valid_strobe_i (hdr_strobe),
        .byte_in_strobe_i          (byte_strobe),
        .byte_in_i                 (byte_in),
        .byte_count_i              (byte_count),
        .demod_is_ongoing_i        (demod),
        .fcs_in_strobe_i           (fcs_strobe),
        .tx_rf_is_ongoing_i        (tx_rf),
        .band_o                    (band),
        .channel_o                 (channel),
        .slot_time_o               (slot_time),
        .sifs_time_o               (sifs_time),
        .mac_addr_o                (mac_addr),
        .tsf_runtime_val_o         (tsf_val),
        .tsf_pulse_1M_o            (tsf_pulse),
        .fc_di_o                   (fc_di),
        .fc_di_valid_o             (fc_di_valid),
        .addr1_o                   (addr1),
        .addr1_valid_o             (addr1_valid),
        .addr2_o                   (addr2),
        .addr2_valid_o             (addr2_valid),
        .pkt_for_me_o              (pkt_for_me),
        .ch_idle_o                 (ch_idle),
        .mute_adc_out_to_bb_o      (mute_adc)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // expected {slot, sifs} from the band and override words
    function automatic logic [13:0] ifs_ref(input xpu_pkg::reg_data_t bw,
                                            input xpu_pkg::reg_data_t ow);
        xpu_pkg::ifs_time_t slot;
        xpu_pkg::ifs_time_t sifs;
        if (ow[31]) begin
            slot = {2'b00, ow[18:14]};
            sifs = ow[13:7];
        end else if (bw[19:16] == 4'd1) begin
            slot = bw[24] ? 7'd9 : 7'd20;
            sifs = 7'd10;
        end else begin
            slot = 7'd9;
            sifs = 7'd16;
        end
        return {slot, sifs};
    endfunction

    // little-endian field of len bytes starting at header index base
    function automatic xpu_pkg::mac_addr_t field_ref(input int base, input int len);
        xpu_pkg::mac_addr_t val;
        val = '0;
        for (int i = 0; i < len; i++) begin
            val[8*i +: 8] = hdr_bytes[base + i];
        end
        return val;
    endfunction

    task automatic report_error(input string msg);
        failures++;
        $display("%s", msg);
    endtask

    task automatic check_ifs(input string name, input xpu_pkg::ifs_time_t act,
                             input xpu_pkg::ifs_time_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_mac(input string name, input xpu_pkg::mac_addr_t act,
                             input xpu_pkg::mac_addr_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_fc(input string name, input xpu_pkg::fc_di_t act,
                            input xpu_pkg::fc_di_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_tsf(input string name, input xpu_pkg::tsf_t act,
                             input xpu_pkg::tsf_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_band(input string name, input xpu_pkg::band_t act,
                              input xpu_pkg::band_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_channel(input string name, input xpu_pkg::channel_t act,
                                 input xpu_pkg::channel_t want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic want);
        checks++;
        if (act !== want) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, want));
        end
    endtask

    // step to just after the next rising edge, where outputs are settled
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s done, %0d failure(s)", name, failures - fail_mark);
        fail_mark = failures;
    endtask

    task automatic reg_write(input xpu_pkg::reg_addr_t addr, input xpu_pkg::reg_data_t data);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        tick();
        reg_wr_en   = 1'b0;
    endtask

    task automatic check_timing();
        logic [13:0] want;
        want = ifs_ref(band_word, ovr_word);
        check_ifs("slot_time_o", slot_time, want[13:7]);
        check_ifs("sifs_time_o", sifs_time, want[6:0]);
    endtask

    task automatic check_flags_clear();
        check_bit("fc_di_valid_o", fc_di_valid, 1'b0);
        check_bit("addr1_valid_o", addr1_valid, 1'b0);
        check_bit("addr2_valid_o", addr2_valid, 1'b0);
        check_bit("pkt_for_me_o", pkt_for_me, 1'b0);
    endtask

    // one 16 byte header, addr1 forced to our mac or away from it
    task automatic run_frame(input bit for_me);
        xpu_pkg::fc_di_t fc_want;
        for (int i = 0; i < 16; i++) begin
            hdr_bytes[i] = 8'($random(seed));
        end
        if (for_me) begin
            for (int i = 0; i < 6; i++) begin
                hdr_bytes[4 + i] = my_mac[8*i +: 8];
            end
        end else if (field_ref(4, 6) == my_mac) begin
            hdr_bytes[4] = hdr_bytes[4] ^ 8'h01;
        end
        fc_want = xpu_pkg::fc_di_t'(field_ref(0, 4));

        hdr_strobe = 1'b1;
        tick();
        hdr_strobe = 1'b0;
        check_flags_clear();

        for (int k = 0; k < 16; k++) begin
            byte_strobe = 1'b1;
            byte_in     = hdr_bytes[k];
            byte_count  = 16'(k);
            tick();
            check_bit("fc_di_valid_o", fc_di_valid, k >= 3);
            check_bit("addr1_valid_o", addr1_valid, k >= 9);
            check_bit("addr2_valid_o", addr2_valid, k >= 15);
            if (k == 3) begin
                check_fc("fc_di_o", fc_di, fc_want);
            end
            if (k == 9) begin
                check_mac("addr1_o", addr1, field_ref(4, 6));
                check_bit("pkt_for_me_o", pkt_for_me, field_ref(4, 6) == my_mac);
            end
            if (k == 15) begin
                check_mac("addr2_o", addr2, field_ref(10, 6));
            end
        end
        byte_strobe = 1'b0;
    endtask

    initial begin
        xpu_pkg::tsf_t load_val;
        int            pulses;
        int            cycles;

        seed        = 32'h4f2f_7a9b;
        tests       = 0;
        checks      = 0;
        failures    = 0;
        fail_mark   = 0;
        band_word   = '0;
        ovr_word    = '0;
        my_mac      = '0;
        rst_n       = 1'b0;
        reg_wr_en   = 1'b0;
        reg_addr    = '0;
        reg_wr_data = '0;
        hdr_strobe  = 1'b0;
        byte_strobe = 1'b0;
        byte_in     = '0;
        byte_count  = '0;
        demod       = 1'b0;
        fcs_strobe  = 1'b0;
        tx_rf       = 1'b0;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // slot and sifs selection
        check_timing();
        band_word = 32'h0001_0000;
        reg_write(xpu_pkg::REG_BAND, band_word);
        check_timing();
        band_word = 32'h0101_0000;
        reg_write(xpu_pkg::REG_BAND, band_word);
        check_timing();
        ovr_word = (32'd1 << 31) | (32'd13 << 14) | (32'd28 << 7);
        reg_write(xpu_pkg::REG_IFS_OVR, ovr_word);
        check_timing();
        ovr_word = '0;
        reg_write(xpu_pkg::REG_IFS_OVR, ovr_word);
        check_timing();
        finish_test("timing_select");

        // band, channel and our address
        band_word = 32'h0002_0024;
        reg_write(xpu_pkg::REG_BAND, band_word);
        check_band("band_o", band, 4'h2);
        check_channel("channel_o", channel, 8'h24);
        check_timing();
        my_mac = {16'($random(seed)), 32'($random(seed))};
        reg_write(xpu_pkg::REG_MAC_LO, my_mac[31:0]);
        reg_write(xpu_pkg::REG_MAC_HI, {16'h0000, my_mac[47:32]});
        check_mac("mac_addr_o", mac_addr, my_mac);
        finish_test("config_fields");

        // header parse, one frame for us and one not
        run_frame(1'b1);
        run_frame(1'b0);
        hdr_strobe = 1'b1;
        tick();
        hdr_strobe = 1'b0;
        check_flags_clear();
        finish_test("header_parse");

        // tsf load then free run
        load_val = {32'h8000_0000 | 32'($random(seed)), 32'($random(seed))};
        reg_write(xpu_pkg::REG_TSF_LO, load_val[31:0]);
        reg_write(xpu_pkg::REG_TSF_HI, load_val[63:32]);
        tick();
        check_tsf("tsf_runtime_val_o", tsf_val, load_val);
        pulses = 0;
        repeat (40) begin
            tick();
            if (tsf_pulse) begin
                pulses++;
            end
        end
        check_tsf("tsf_runtime_val_o", tsf_val, load_val + 64'(pulses));
        if (pulses != 40 / CLK_PER_US) begin
            report_error($sformatf("saw %0d us pulses in 40 clocks, expected %0d",
                                   pulses, 40 / CLK_PER_US));
        end
        finish_test("tsf_timer");

        // channel idle through rx, post-fcs wait and tx
        reg_write(xpu_pkg::REG_WAIT, 32'd3);
        check_bit("ch_idle_o", ch_idle, 1'b1);
        demod = 1'b1;
        tick();
        check_bit("ch_idle_o", ch_idle, 1'b0);
        demod = 1'b0;
        tick();
        check_bit("ch_idle_o", ch_idle, 1'b0);
        fcs_strobe = 1'b1;
        tick();
        fcs_strobe = 1'b0;
        pulses = 0;
        cycles = 0;
        while (!ch_idle && cycles < 10 * CLK_PER_US) begin
            if (tsf_pulse) begin
                pulses++;
            end
            tick();
            cycles++;
        end
        if (!ch_idle) begin
            report_error("timeout: channel never went idle after the post-fcs wait");
        end else if (pulses != 3) begin
            report_error($sformatf("channel went idle after %0d us pulses instead of 3", pulses));
        end
        tx_rf = 1'b1;
        tick();
        check_bit("ch_idle_o", ch_idle, 1'b0);
        repeat (3) tick();
        check_bit("ch_idle_o", ch_idle, 1'b0);
        tx_rf = 1'b0;
        tick();
        check_bit("ch_idle_o", ch_idle, 1'b1);
        finish_test("channel_idle");

        // adc mute, then the override both ways
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b0);
        tx_rf = 1'b1;
        tick();
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b1);
        tx_rf = 1'b0;
        tick();
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b0);
        reg_write(xpu_pkg::REG_MUTE, 32'h8000_0001);
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b1);
        tx_rf = 1'b1;
        repeat (2) tick();
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b1);
        reg_write(xpu_pkg::REG_MUTE, 32'h0000_0001);
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b0);
        reg_write(xpu_pkg::REG_MUTE, 32'h0000_0000);
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b1);
        tx_rf = 1'b0;
        tick();
        check_bit("mute_adc_out_to_bb_o", mute_adc, 1'b0);
        finish_test("adc_mute");

        $display("tests %0d, checks %0d, failures %0d", tests, checks, failures);
        if (failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== xpu.sv ====
// xpu rx and timekeeping core top; CLK_PER_US is clock cycles per us and must be at least 2
`timescale 1ns/1ns

module xpu #(
    parameter int CLK_PER_US = 100
) (
    input  logic               s00_axi_aclk_i,
    input  logic               rst_n_i,
    input  logic               reg_wr_en_i,
    input  xpu_pkg::reg_addr_t reg_addr_i,
    input  xpu_pkg::reg_data_t reg_wr_data_i,
    input  logic               pkt_header_valid_strobe_i,
    input  logic               byte_in_strobe_i,
    input  logic [7:0]         byte_in_i,
    input  logic [15:0]        byte_count_i,
    input  logic               demod_is_ongoing_i,
    input  logic               fcs_in_strobe_i,
    input  logic               tx_rf_is_ongoing_i,
    output xpu_pkg::band_t     band_o,
    output xpu_pkg::channel_t  channel_o,
    output xpu_pkg::ifs_time_t slot_time_o,
    output xpu_pkg::ifs_time_t sifs_time_o,
    output xpu_pkg::mac_addr_t mac_addr_o,
    output xpu_pkg::tsf_t      tsf_runtime_val_o,
    output logic               tsf_pulse_1M_o,
    output xpu_pkg::fc_di_t    fc_di_o,
    output logic               fc_di_valid_o,
    output xpu_pkg::mac_addr_t addr1_o,
    output logic               addr1_valid_o,
    output xpu_pkg::mac_addr_t addr2_o,
    output logic               addr2_valid_o,
    output logic               pkt_for_me_o,
    output logic               ch_idle_o,
    output logic               mute_adc_out_to_bb_o
);

    xpu_pkg::wait_top_t wait_after_decode_top;
    xpu_pkg::tsf_t      tsf_load_val;
    logic               tsf_load_ctrl;
    logic               mute_ovr_en;
    logic               mute_ovr_val;

    xpu_cfg_regs xpu_cfg_regs_i (
        .s00_axi_aclk_i          (s00_axi_aclk_i),
        .rst_n_i                 (rst_n_i),
        .reg_wr_en_i             (reg_wr_en_i),
        .reg_addr_i              (reg_addr_i),
        .reg_wr_data_i           (reg_wr_data_i),
        .band_o                  (band_o),
        .channel_o               (channel_o),
        .slot_time_o             (slot_time_o),
        .sifs_time_o             (sifs_time_o),
        .mac_addr_o              (mac_addr_o),
        .wait_after_decode_top_o (wait_after_decode_top),
        .mute_ovr_en_o           (mute_ovr_en),
        .mute_ovr_val_o          (mute_ovr_val),
        .tsf_load_ctrl_o         (tsf_load_ctrl),
        .tsf_load_val_o          (tsf_load_val)
    );

    tsf_timer #(
        .CLK_PER_US (CLK_PER_US)
    ) tsf_timer_i (
        .s00_axi_aclk_i    (s00_axi_aclk_i),
        .rst_n_i           (rst_n_i),
        .tsf_load_ctrl_i   (tsf_load_ctrl),
        .tsf_load_val_i    (tsf_load_val),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1M_o    (tsf_pulse_1M_o)
    );

    phy_rx_parse phy_rx_parse_i (
        .s00_axi_aclk_i            (s00_axi_aclk_i),
        .rst_n_i                   (rst_n_i),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .byte_in_i                 (byte_in_i),
        .byte_count_i              (byte_count_i),
        .mac_addr_i                (mac_addr_o),
        .fc_di_o                   (fc_di_o),
        .fc_di_valid_o             (fc_di_valid_o),
        .addr1_o                   (addr1_o),
        .addr2_o                   (addr2_o),
        .addr1_valid_o             (addr1_valid_o),
        .addr2_valid_o             (addr2_valid_o),
        .pkt_for_me_o              (pkt_for_me_o)
    );

    xpu_ctrl xpu_ctrl_i (
        .s00_axi_aclk_i          (s00_axi_aclk_i),
        .rst_n_i                 (rst_n_i),
        .demod_is_ongoing_i      (demod_is_ongoing_i),
        .tx_rf_is_ongoing_i      (tx_rf_is_ongoing_i),
        .fcs_in_strobe_i         (fcs_in_strobe_i),
        .tsf_pulse_1M_i          (tsf_pulse_1M_o),
        .wait_after_decode_top_i (wait_after_decode_top),
        .mute_ovr_en_i           (mute_ovr_en),
        .mute_ovr_val_i          (mute_ovr_val),
        .ch_idle_o               (ch_idle_o),
        .mute_adc_out_to_bb_o    (mute_adc_out_to_bb_o)
    );

endmodule

// ==== xpu_ctrl.sv ====
// channel idle FSM and adc mute; the post-fcs wait counts tsf us pulses, so it ends up to one us early
`timescale 1ns/1ns

module xpu_ctrl (
    input  logic               s00_axi_aclk_i,
    input  logic               rst_n_i,
    input  logic               demod_is_ongoing_i,
    input  logic               tx_rf_is_ongoing_i,
    input  logic               fcs_in_strobe_i,
    input  logic               tsf_pulse_1M_i,
    input  xpu_pkg::wait_top_t wait_after_decode_top_i,
    input  logic               mute_ovr_en_i,
    input  logic               mute_ovr_val_i,
    output logic               ch_idle_o,
    output logic               mute_adc_out_to_bb_o
);

    xpu_pkg::ch_state_t state;
    xpu_pkg::ch_state_t state_nxt;
    xpu_pkg::wait_top_t wait_cnt;
    logic               tx_mute_q;

    always_comb begin
        state_nxt = state;
        case (state)
            xpu_pkg::CH_IDLE: begin
                // own tx takes priority over rx
                if (tx_rf_is_ongoing_i) begin
                    state_nxt = xpu_pkg::CH_TX;
                end else if (demod_is_ongoing_i) begin
                    state_nxt = xpu_pkg::CH_RX;
                end
            end
            xpu_pkg::CH_RX: begin
                if (tx_rf_is_ongoing_i) begin
                    state_nxt = xpu_pkg::CH_TX;
                end else if (fcs_in_strobe_i) begin
                    if (wait_after_decode_top_i == '0) begin
                        state_nxt = xpu_pkg::CH_IDLE;
                    end else begin
                        state_nxt = xpu_pkg::CH_WAIT;
                    end
                end
            end
            xpu_pkg::CH_WAIT: begin
                if (tx_rf_is_ongoing_i) begin
                    state_nxt = xpu_pkg::CH_TX;
                end else if (tsf_pulse_1M_i && wait_cnt == 8'd1) begin
                    state_nxt = xpu_pkg::CH_IDLE;
                end
            end
            xpu_pkg::CH_TX: begin
                if (!tx_rf_is_ongoing_i) begin
                    state_nxt = xpu_pkg::CH_IDLE;
                end
            end
            default: state_nxt = xpu_pkg::CH_IDLE;
        endcase
    end

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            state     <= xpu_pkg::CH_IDLE;
            wait_cnt  <= '0;
            tx_mute_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            tx_mute_q <= tx_rf_is_ongoing_i;
            if (state == xpu_pkg::CH_RX && fcs_in_strobe_i) begin
                wait_cnt <= wait_after_decode_top_i;
            end else if (state == xpu_pkg::CH_WAIT && tsf_pulse_1M_i) begin
                wait_cnt <= wait_cnt - 8'd1;
            end
        end
    end

    assign ch_idle_o = (state == xpu_pkg::CH_IDLE);

    // debug override, else mute self rx during tx
    assign mute_adc_out_to_bb_o = mute_ovr_en_i ? mute_ovr_val_i : tx_mute_q;

    a_no_idle_in_tx: assert property (@(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        (tx_rf_is_ongoing_i && $past(tx_rf_is_ongoing_i)) |-> !ch_idle_o);

endmodule

// ==== phy_rx_parse.sv ====
// header byte parser for fc/duration, addr1 and addr2; assumes at most one byte per cycle, in index order
`timescale 1ns/1ns

module phy_rx_parse (
    input  logic               s00_axi_aclk_i,
    input  logic               rst_n_i,
    input  logic               pkt_header_valid_strobe_i,
    input  logic               byte_in_strobe_i,
    input  logic [7:0]         byte_in_i,
    input  logic [15:0]        byte_count_i,
    input  xpu_pkg::mac_addr_t mac_addr_i,
    output xpu_pkg::fc_di_t    fc_di_o,
    output logic               fc_di_valid_o,
    output xpu_pkg::mac_addr_t addr1_o,
    output xpu_pkg::mac_addr_t addr2_o,
    output logic               addr1_valid_o,
    output logic               addr2_valid_o,
    output logic               pkt_for_me_o
);

    logic [15:0]        addr1_sel;
    logic [15:0]        addr2_sel;
    xpu_pkg::mac_addr_t addr1_full;

    // byte offset inside each address
    assign addr1_sel = byte_count_i - 16'd4;
    assign addr2_sel = byte_count_i - 16'd10;

    // addr1 as it will look once its last byte lands
    assign addr1_full = {byte_in_i, addr1_o[39:0]};

    always_ff @(posedge s00_axi_aclk_i) begin
        if (byte_in_strobe_i) begin
            if (byte_count_i <= 16'd3) begin
                fc_di_o[8*byte_count_i[1:0] +: 8] <= byte_in_i;
            end else if (byte_count_i <= 16'd9) begin
                addr1_o[8*addr1_sel[2:0] +: 8] <= byte_in_i;
            end else if (byte_count_i <= 16'd15) begin
                addr2_o[8*addr2_sel[2:0] +: 8] <= byte_in_i;
            end
        end
    end

    // valid levels, cleared at each new header
    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i || pkt_header_valid_strobe_i) begin
            fc_di_valid_o <= 1'b0;
            addr1_valid_o <= 1'b0;
            addr2_valid_o <= 1'b0;
            pkt_for_me_o  <= 1'b0;
        end else if (byte_in_strobe_i) begin
            if (byte_count_i == 16'd3) begin
                fc_di_valid_o <= 1'b1;
            end
            if (byte_count_i == 16'd9) begin
                addr1_valid_o <= 1'b1;
                pkt_for_me_o  <= (addr1_full == mac_addr_i);
            end
            if (byte_count_i == 16'd15) begin
                addr2_valid_o <= 1'b1;
            end
        end
    end

    a_addr_order: assert property (@(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        addr2_valid_o |-> addr1_valid_o);

endmodule

// ==== tsf_timer.sv ====
// 64-bit us counter; CLK_PER_US must be at least 2 and the load acts on a rising edge of the control bit only
`timescale 1ns/1ns

module tsf_timer #(
    parameter int CLK_PER_US = 100
) (
    input  logic          s00_axi_aclk_i,
    input  logic          rst_n_i,
    input  logic          tsf_load_ctrl_i,
    input  xpu_pkg::tsf_t tsf_load_val_i,
    output xpu_pkg::tsf_t tsf_runtime_val_o,
    output logic          tsf_pulse_1M_o
);

    localparam int DIV_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             load_ctrl_d;
    logic             load_edge;

    assign load_edge = tsf_load_ctrl_i & ~load_ctrl_d;

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            load_ctrl_d       <= 1'b0;
            div_cnt           <= '0;
            tsf_pulse_1M_o    <= 1'b0;
            tsf_runtime_val_o <= '0;
        end else begin
            load_ctrl_d <= tsf_load_ctrl_i;
            if (load_edge) begin
                // restart divider so the first us after load is a full one
                div_cnt           <= '0;
                tsf_pulse_1M_o    <= 1'b0;
                tsf_runtime_val_o <= tsf_load_val_i;
            end else if (div_cnt == DIV_W'(CLK_PER_US - 1)) begin
                div_cnt           <= '0;
                tsf_pulse_1M_o    <= 1'b1;
                tsf_runtime_val_o <= tsf_runtime_val_o + 64'd1;
            end else begin
                div_cnt        <= div_cnt + 1'b1;
                tsf_pulse_1M_o <= 1'b0;
            end
        end
    end

    a_pulse_single: assert property (@(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        tsf_pulse_1M_o |=> !tsf_pulse_1M_o);

endmodule

// ==== xpu_cfg_regs.sv ====
// write-only register bank with no handshake; unlisted indices are dropped and fields update one cycle after the strobe
`timescale 1ns/1ns

module xpu_cfg_regs (
    input  logic                s00_axi_aclk_i,
    input  logic                rst_n_i,
    input  logic                reg_wr_en_i,
    input  xpu_pkg::reg_addr_t  reg_addr_i,
    input  xpu_pkg::reg_data_t  reg_wr_data_i,
    output xpu_pkg::band_t      band_o,
    output xpu_pkg::channel_t   channel_o,
    output xpu_pkg::ifs_time_t  slot_time_o,
    output xpu_pkg::ifs_time_t  sifs_time_o,
    output xpu_pkg::mac_addr_t  mac_addr_o,
    output xpu_pkg::wait_top_t  wait_after_decode_top_o,
    output logic                mute_ovr_en_o,
    output logic                mute_ovr_val_o,
    output logic                tsf_load_ctrl_o,
    output xpu_pkg::tsf_t       tsf_load_val_o
);

    xpu_pkg::reg_data_t reg_mute;
    xpu_pkg::reg_data_t reg_tsf_lo;
    xpu_pkg::reg_data_t reg_tsf_hi;
    xpu_pkg::reg_data_t reg_band;
    xpu_pkg::reg_data_t reg_wait;
    xpu_pkg::reg_data_t reg_ifs_ovr;
    xpu_pkg::reg_data_t reg_mac_lo;
    xpu_pkg::reg_data_t reg_mac_hi;
    logic               erp_short_slot;

    always_ff @(posedge s00_axi_aclk_i) begin
        if (!rst_n_i) begin
            reg_mute    <= '0;
            reg_tsf_lo  <= '0;
            reg_tsf_hi  <= '0;
            reg_band    <= '0;
            reg_wait    <= '0;
            reg_ifs_ovr <= '0;
            reg_mac_lo  <= '0;
            reg_mac_hi  <= '0;
        end else if (reg_wr_en_i) begin
            case (reg_addr_i)
                xpu_pkg::REG_MUTE:    reg_mute    <= reg_wr_data_i;
                xpu_pkg::REG_TSF_LO:  reg_tsf_lo  <= reg_wr_data_i;
                xpu_pkg::REG_TSF_HI:  reg_tsf_hi  <= reg_wr_data_i;
                xpu_pkg::REG_BAND:    reg_band    <= reg_wr_data_i;
                xpu_pkg::REG_WAIT:    reg_wait    <= reg_wr_data_i;
                xpu_pkg::REG_IFS_OVR: reg_ifs_ovr <= reg_wr_data_i;
                xpu_pkg::REG_MAC_LO:  reg_mac_lo  <= reg_wr_data_i;
                xpu_pkg::REG_MAC_HI:  reg_mac_hi  <= reg_wr_data_i;
                default: ;
            endcase
        end
    end

    // field decode
    assign erp_short_slot          = reg_band[24];
    assign band_o                  = reg_band[19:16];
    assign channel_o               = reg_band[7:0];
    assign wait_after_decode_top_o = reg_wait[7:0];
    assign mac_addr_o              = {reg_mac_hi[15:0], reg_mac_lo};
    assign mute_ovr_en_o           = reg_mute[0];
    assign mute_ovr_val_o          = reg_mute[31];

    // msb of the high word doubles as the load trigger
    assign tsf_load_ctrl_o = reg_tsf_hi[31];
    assign tsf_load_val_o  = {reg_tsf_hi, reg_tsf_lo};

    // debug override wins, else band rules
    always_comb begin
        if (reg_ifs_ovr[31]) begin
            slot_time_o = {2'b00, reg_ifs_ovr[18:14]};
            sifs_time_o = reg_ifs_ovr[13:7];
        end else if (band_o == 4'd1) begin
            slot_time_o = erp_short_slot ? xpu_pkg::SLOT_SHORT_US : xpu_pkg::SLOT_LONG_US;
            sifs_time_o = xpu_pkg::SIFS_2G4_US;
        end else begin
            slot_time_o = xpu_pkg::SLOT_SHORT_US;
            sifs_time_o = xpu_pkg::SIFS_5G_US;
        end
    end

    a_wr_addr_known: assert property (@(posedge s00_axi_aclk_i) disable iff (!rst_n_i)
        reg_wr_en_i |-> !$isunknown(reg_addr_i));

endmodule

// ==== xpu_pkg.sv ====
// shared widths, register word indices and 802.11 timing defaults for the xpu core; no timescale
package xpu_pkg;

    // register bank
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // first received byte of an address lands in bits 7:0
    typedef logic [47:0] mac_addr_t;

    // tsf in microseconds
    typedef logic [63:0] tsf_t;

    // frame control in 15:0, duration in 31:16
    typedef logic [31:0] fc_di_t;

    // band code, 1 is 2.4 GHz
    typedef logic [3:0]  band_t;
    typedef logic [7:0]  channel_t;
    typedef logic [6:0]  ifs_time_t;
    typedef logic [7:0]  wait_top_t;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_RX,
        CH_WAIT,
        CH_TX
    } ch_state_t;

    // register word indices
    localparam reg_addr_t REG_MUTE    = 5'd1;
    localparam reg_addr_t REG_TSF_LO  = 5'd2;
    localparam reg_addr_t REG_TSF_HI  = 5'd3;
    localparam reg_addr_t REG_BAND    = 5'd4;
    localparam reg_addr_t REG_WAIT    = 5'd6;
    localparam reg_addr_t REG_IFS_OVR = 5'd9;
    localparam reg_addr_t REG_MAC_LO  = 5'd30;
    localparam reg_addr_t REG_MAC_HI  = 5'd31;

    // slot and sifs defaults in us
    localparam ifs_time_t SLOT_LONG_US  = 7'd20;
    localparam ifs_time_t SLOT_SHORT_US = 7'd9;
    localparam ifs_time_t SIFS_2G4_US   = 7'd10;
    localparam ifs_time_t SIFS_5G_US    = 7'd16;

endpackage
